// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // datapath and register word
    localparam int DATA_W     = 16;
    // eight architectural registers
    localparam int REG_ADDR_W = 3;
    // immediate field, zero-extended on use
    localparam int IMM_W      = 8;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // instr[15:13]
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_LDI = 3'd4,
        OP_LD  = 3'd5,
        OP_ST  = 3'd6,
        OP_NOP = 3'd7
    } opcode_e;

    // alu function select, carried in the control word
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_a,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_b,
    input  logic                          wr_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [cpu_pkg::DATA_W-1:0]     wr_data,
    output logic [cpu_pkg::DATA_W-1:0]     rd_data_a,
    output logic [cpu_pkg::DATA_W-1:0]     rd_data_b
);

    localparam int NUM_REGS = 2 ** cpu_pkg::REG_ADDR_W;

    // architectural registers
    logic [cpu_pkg::DATA_W-1:0] regs [NUM_REGS];

    // write port, all registers cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read ports
    // same-cycle write is passed through, so the decode register
    // catches the new value at the write edge
    always_comb begin
        rd_data_a = regs[rd_addr_a];
        rd_data_b = regs[rd_addr_b];
        if (wr_en && (wr_addr == rd_addr_a)) begin
            rd_data_a = wr_data;
        end
        if (wr_en && (wr_addr == rd_addr_b)) begin
            rd_data_b = wr_data;
        end
    end

endmodule

`default_nettype wire

// File: design/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::opcode_e  opcode,
    input  logic              valid,
    output cpu_pkg::alu_op_e  alu_op,
    output logic              mem_read,
    output logic              mem_write,
    output logic              wb,
    output logic              imm_select
);

    // next control word
    cpu_pkg::alu_op_e alu_op_nxt;
    logic             mem_read_nxt;
    logic             mem_write_nxt;
    logic             wb_nxt;
    logic             imm_select_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op_nxt     = cpu_pkg::ALU_ADD;
        mem_read_nxt   = 1'b0;
        mem_write_nxt  = 1'b0;
        wb_nxt         = 1'b0;
        imm_select_nxt = 1'b0;
        // bubble -> all zero, no side effects downstream
        if (valid) begin
            case (opcode)
                cpu_pkg::OP_ADD: begin
                    alu_op_nxt = cpu_pkg::ALU_ADD;
                    wb_nxt     = 1'b1;
                end
                cpu_pkg::OP_SUB: begin
                    alu_op_nxt = cpu_pkg::ALU_SUB;
                    wb_nxt     = 1'b1;
                end
                cpu_pkg::OP_AND: begin
                    alu_op_nxt = cpu_pkg::ALU_AND;
                    wb_nxt     = 1'b1;
                end
                cpu_pkg::OP_OR: begin
                    alu_op_nxt = cpu_pkg::ALU_OR;
                    wb_nxt     = 1'b1;
                end
                // immediate bypasses the alu
                cpu_pkg::OP_LDI: begin
                    imm_select_nxt = 1'b1;
                    wb_nxt         = 1'b1;
                end
                cpu_pkg::OP_LD: begin
                    mem_read_nxt = 1'b1;
                    wb_nxt       = 1'b1;
                end
                cpu_pkg::OP_ST: begin
                    mem_write_nxt = 1'b1;
                end
                // nop retires with nothing set
                default: begin
                end
            endcase
        end
    end

    // buffered control word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_op     <= cpu_pkg::ALU_ADD;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            wb         <= 1'b0;
            imm_select <= 1'b0;
        end else begin
            alu_op     <= alu_op_nxt;
            mem_read   <= mem_read_nxt;
            mem_write  <= mem_write_nxt;
            wb         <= wb_nxt;
            imm_select <= imm_select_nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/decoding_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decoding_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [cpu_pkg::DATA_W-1:0]     instr,
    input  logic                           wr_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [cpu_pkg::DATA_W-1:0]     wr_data,
    output logic                           d_valid,
    output cpu_pkg::alu_op_e               alu_op,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic                           wb,
    output logic                           imm_select,
    output logic [cpu_pkg::DATA_W-1:0]     operand_a,
    output logic [cpu_pkg::DATA_W-1:0]     operand_b,
    output logic [cpu_pkg::IMM_W-1:0]      imm,
    output logic [cpu_pkg::REG_ADDR_W-1:0] dst_addr
);

    ////////////////////////////////////////////////////////////////////////////
    // field split
    ////////////////////////////////////////////////////////////////////////////

    // opcode | rd | rs | imm, rs and imm share bit 7
    cpu_pkg::opcode_e               opcode;
    logic [cpu_pkg::REG_ADDR_W-1:0] rd_idx;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs_idx;
    logic [cpu_pkg::DATA_W-1:0]     rd_val;
    logic [cpu_pkg::DATA_W-1:0]     rs_val;

    assign opcode = cpu_pkg::opcode_e'(instr[15:13]);
    assign rd_idx = instr[12:10];
    assign rs_idx = instr[9:7];

    // rd is also the first source
    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rd_idx),
        .rd_addr_b (rs_idx),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_val),
        .rd_data_b (rs_val)
    );

    // control word registered inside
    control_unit u_control_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .valid      (instr_valid),
        .alu_op     (alu_op),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .wb         (wb),
        .imm_select (imm_select)
    );

    ////////////////////////////////////////////////////////////////////////////
    // decode pipeline register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= instr_valid;
        end
    end

    // payload beside the control word
    always_ff @(posedge clk) begin
        operand_a <= rd_val;
        operand_b <= rs_val;
        imm       <= instr[cpu_pkg::IMM_W-1:0];
        dst_addr  <= rd_idx;
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           d_valid,
    input  cpu_pkg::alu_op_e               alu_op,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic                           wb,
    input  logic                           imm_select,
    input  logic [cpu_pkg::DATA_W-1:0]     operand_a,
    input  logic [cpu_pkg::DATA_W-1:0]     operand_b,
    input  logic [cpu_pkg::IMM_W-1:0]      imm,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] dst_addr,
    output logic                           e_valid,
    output logic [cpu_pkg::DATA_W-1:0]     result,
    output logic [cpu_pkg::DATA_W-1:0]     store_data,
    output logic [cpu_pkg::DATA_W-1:0]     mem_addr_src,
    output logic                           e_mem_read,
    output logic                           e_mem_write,
    output logic                           e_wb,
    output logic [cpu_pkg::REG_ADDR_W-1:0] e_dst_addr
);

    logic [cpu_pkg::DATA_W-1:0] alu_out;
    logic [cpu_pkg::DATA_W-1:0] imm_ext;
    logic [cpu_pkg::DATA_W-1:0] result_nxt;

    // zero-extend for ldi
    assign imm_ext = {{(cpu_pkg::DATA_W - cpu_pkg::IMM_W){1'b0}}, imm};

    // alu, carry out dropped
    always_comb begin
        alu_out = '0;
        case (alu_op)
            cpu_pkg::ALU_ADD: alu_out = operand_a + operand_b;
            cpu_pkg::ALU_SUB: alu_out = operand_a - operand_b;
            cpu_pkg::ALU_AND: alu_out = operand_a & operand_b;
            cpu_pkg::ALU_OR:  alu_out = operand_a | operand_b;
            default:          alu_out = '0;
        endcase
    end

    assign result_nxt = imm_select ? imm_ext : alu_out;

    ////////////////////////////////////////////////////////////////////////////
    // execute pipeline register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_valid     <= 1'b0;
            e_mem_read  <= 1'b0;
            e_mem_write <= 1'b0;
            e_wb        <= 1'b0;
        end else begin
            e_valid     <= d_valid;
            e_mem_read  <= mem_read;
            e_mem_write <= mem_write;
            e_wb        <= wb;
        end
    end

    // rd value is the store data, rs value the address
    always_ff @(posedge clk) begin
        result       <= result_nxt;
        store_data   <= operand_a;
        mem_addr_src <= operand_b;
        e_dst_addr   <= dst_addr;
    end

endmodule

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
    parameter int DMEM_ADDR_W = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           e_valid,
    input  logic [cpu_pkg::DATA_W-1:0]     result,
    input  logic [cpu_pkg::DATA_W-1:0]     store_data,
    input  logic [cpu_pkg::DATA_W-1:0]     mem_addr_src,
    input  logic                           e_mem_read,
    input  logic                           e_mem_write,
    input  logic                           e_wb,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] e_dst_addr,
    output logic                           retire_valid,
    output logic                           wb_en,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [cpu_pkg::DATA_W-1:0]     wb_data,
    output logic                           st_en,
    output logic [DMEM_ADDR_W-1:0]         st_addr,
    output logic [cpu_pkg::DATA_W-1:0]     st_data
);

    localparam int DEPTH = 2 ** DMEM_ADDR_W;

    logic [cpu_pkg::DATA_W-1:0] dmem [DEPTH];
    logic [DMEM_ADDR_W-1:0]     addr;
    logic [cpu_pkg::DATA_W-1:0] load_data;

    // word address from the low bits of rs
    assign addr      = mem_addr_src[DMEM_ADDR_W-1:0];
    assign load_data = dmem[addr];

    // data memory, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (e_mem_write) begin
            dmem[addr] <= store_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // retire register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            wb_en        <= 1'b0;
            st_en        <= 1'b0;
        end else begin
            retire_valid <= e_valid;
            wb_en        <= e_wb;
            st_en        <= e_mem_write;
        end
    end

    // loads retire the memory word, everything else the alu result
    always_ff @(posedge clk) begin
        wb_addr <= e_dst_addr;
        wb_data <= e_mem_read ? load_data : result;
        st_addr <= addr;
        st_data <= store_data;
    end

endmodule

`default_nettype wire

// File: design/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter int DMEM_ADDR_W = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [cpu_pkg::DATA_W-1:0]     instr,
    output logic                           retire_valid,
    output logic                           wb_en,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [cpu_pkg::DATA_W-1:0]     wb_data,
    output logic                           st_en,
    output logic [DMEM_ADDR_W-1:0]         st_addr,
    output logic [cpu_pkg::DATA_W-1:0]     st_data
);

    ////////////////////////////////////////////////////////////////////////////
    // stage D outputs
    ////////////////////////////////////////////////////////////////////////////

    logic                           d_valid;
    cpu_pkg::alu_op_e               d_alu_op;
    logic                           d_mem_read;
    logic                           d_mem_write;
    logic                           d_wb;
    logic                           d_imm_select;
    logic [cpu_pkg::DATA_W-1:0]     d_operand_a;
    logic [cpu_pkg::DATA_W-1:0]     d_operand_b;
    logic [cpu_pkg::IMM_W-1:0]      d_imm;
    logic [cpu_pkg::REG_ADDR_W-1:0] d_dst_addr;

    // stage E outputs
    logic                           e_valid;
    logic [cpu_pkg::DATA_W-1:0]     e_result;
    logic [cpu_pkg::DATA_W-1:0]     e_store_data;
    logic [cpu_pkg::DATA_W-1:0]     e_mem_addr_src;
    logic                           e_mem_read;
    logic                           e_mem_write;
    logic                           e_wb;
    logic [cpu_pkg::REG_ADDR_W-1:0] e_dst_addr;

    // write-back loops into the register file write port
    decoding_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wr_en       (wb_en),
        .wr_addr     (wb_addr),
        .wr_data     (wb_data),
        .d_valid     (d_valid),
        .alu_op      (d_alu_op),
        .mem_read    (d_mem_read),
        .mem_write   (d_mem_write),
        .wb          (d_wb),
        .imm_select  (d_imm_select),
        .operand_a   (d_operand_a),
        .operand_b   (d_operand_b),
        .imm         (d_imm),
        .dst_addr    (d_dst_addr)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .d_valid      (d_valid),
        .alu_op       (d_alu_op),
        .mem_read     (d_mem_read),
        .mem_write    (d_mem_write),
        .wb           (d_wb),
        .imm_select   (d_imm_select),
        .operand_a    (d_operand_a),
        .operand_b    (d_operand_b),
        .imm          (d_imm),
        .dst_addr     (d_dst_addr),
        .e_valid      (e_valid),
        .result       (e_result),
        .store_data   (e_store_data),
        .mem_addr_src (e_mem_addr_src),
        .e_mem_read   (e_mem_read),
        .e_mem_write  (e_mem_write),
        .e_wb         (e_wb),
        .e_dst_addr   (e_dst_addr)
    );

    // memory depth set here
    memory_stage #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_memory (
        .clk          (clk),
        .rst_n        (rst_n),
        .e_valid      (e_valid),
        .result       (e_result),
        .store_data   (e_store_data),
        .mem_addr_src (e_mem_addr_src),
        .e_mem_read   (e_mem_read),
        .e_mem_write  (e_mem_write),
        .e_wb         (e_wb),
        .e_dst_addr   (e_dst_addr),
        .retire_valid (retire_valid),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .st_en        (st_en),
        .st_addr      (st_addr),
        .st_data      (st_data)
    );

endmodule

`default_nettype wire

// File: verif/cpu_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_assertions (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic retire_valid,
    input logic wb_en,
    input logic st_en
);

    // retire follows issue by three edges, one for one
    retire_latency: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid == $past(instr_valid, 3))
        else $error("retire_valid does not follow instr_valid by 3 cycles");

    // side effects only with a retire
    wb_needs_retire: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> retire_valid)
        else $error("wb_en high without retire_valid");

    st_needs_retire: assert property (@(posedge clk) disable iff (!rst_n)
        st_en |-> retire_valid)
        else $error("st_en high without retire_valid");

    // no opcode both writes a register and stores
    wb_st_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_en && st_en))
        else $error("wb_en and st_en high together");

    retire_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!retire_valid && !wb_en && !st_en))
        else $error("retire outputs active during reset");

endmodule

bind cpu_core cpu_core_assertions u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .retire_valid (retire_valid),
    .wb_en        (wb_en),
    .st_en        (st_en)
);

`default_nettype wire

// File: verif/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

    localparam int DMEM_ADDR_W  = 4;
    localparam int DMEM_DEPTH   = 2 ** DMEM_ADDR_W;
    localparam int NUM_INSTR    = 400;
    localparam int SLOTS        = 3;
    localparam int LATENCY      = 3;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    // issue slots plus reset plus drain margin
    localparam int TIMEOUT_NS   = NUM_INSTR * SLOTS * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD + 1000;

    // one expected retire, stamped with its issue cycle
    typedef struct packed {
        logic [31:0]                    issue;
        logic                           wb_en;
        logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr;
        logic [cpu_pkg::DATA_W-1:0]     wb_data;
        logic                           st_en;
        logic [DMEM_ADDR_W-1:0]         st_addr;
        logic [cpu_pkg::DATA_W-1:0]     st_data;
    } retire_rec_t;

    logic                           clk;
    logic                           rst_n;
    logic                           instr_valid;
    logic [cpu_pkg::DATA_W-1:0]     instr;
    logic                           retire_valid;
    logic                           wb_en;
    logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr;
    logic [cpu_pkg::DATA_W-1:0]     wb_data;
    logic                           st_en;
    logic [DMEM_ADDR_W-1:0]         st_addr;
    logic [cpu_pkg::DATA_W-1:0]     st_data;

    logic [31:0]                    rng_state;
    logic [31:0]                    cycle;
    logic [cpu_pkg::DATA_W-1:0]     model_regs [8];
    logic [cpu_pkg::DATA_W-1:0]     model_mem [DMEM_DEPTH];
    retire_rec_t                    expected_q [$];

    cpu_core #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .st_en        (st_en),
        .st_addr      (st_addr),
        .st_data      (st_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) begin
        cycle = cycle + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // 32-bit lcg, upper bits are the useful ones
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // architectural effect of one instruction, applied at issue
    task automatic apply_model(input logic [cpu_pkg::DATA_W-1:0] word);
        retire_rec_t                    rec;
        cpu_pkg::opcode_e               op;
        logic [cpu_pkg::REG_ADDR_W-1:0] rd;
        logic [cpu_pkg::REG_ADDR_W-1:0] rs;
        logic [cpu_pkg::DATA_W-1:0]     a;
        logic [cpu_pkg::DATA_W-1:0]     b;
        logic [DMEM_ADDR_W-1:0]         addr;
        op   = cpu_pkg::opcode_e'(word[15:13]);
        rd   = word[12:10];
        rs   = word[9:7];
        a    = model_regs[rd];
        b    = model_regs[rs];
        addr = b[DMEM_ADDR_W-1:0];
        rec  = '0;
        rec.issue   = cycle;
        rec.wb_addr = rd;
        case (op)
            cpu_pkg::OP_ADD: begin
                rec.wb_en   = 1'b1;
                rec.wb_data = a + b;
            end
            cpu_pkg::OP_SUB: begin
                rec.wb_en   = 1'b1;
                rec.wb_data = a - b;
            end
            cpu_pkg::OP_AND: begin
                rec.wb_en   = 1'b1;
                rec.wb_data = a & b;
            end
            cpu_pkg::OP_OR: begin
                rec.wb_en   = 1'b1;
                rec.wb_data = a | b;
            end
            cpu_pkg::OP_LDI: begin
                rec.wb_en   = 1'b1;
                rec.wb_data = {8'h00, word[7:0]};
            end
            cpu_pkg::OP_LD: begin
                rec.wb_en   = 1'b1;
                rec.wb_data = model_mem[addr];
            end
            cpu_pkg::OP_ST: begin
                rec.st_en      = 1'b1;
                rec.st_addr    = addr;
                rec.st_data    = a;
                model_mem[addr] = a;
            end
            // nop, no effect
            default: begin
            end
        endcase
        if (rec.wb_en) begin
            model_regs[rd] = rec.wb_data;
        end
        expected_q.push_back(rec);
    endtask

    // one valid slot, then two bubbles with junk on instr
    task automatic issue_instr(input logic [cpu_pkg::DATA_W-1:0] word);
        logic [31:0] junk;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        apply_model(word);
        repeat (SLOTS - 1) begin
            @(negedge clk);
            junk        = next_random();
            instr_valid = 1'b0;
            instr       = junk[31:16];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // retire monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : retire_monitor
        retire_rec_t rec;
        if (rst_n && retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("retire at %0t ns with no instruction in flight", $time);
                $display("TEST FAILED");
                $fatal(1, "unexpected retire");
            end else begin
                rec = expected_q.pop_front();
                check_value("retire latency", cycle - rec.issue, LATENCY);
                check_value("wb_en", 32'(wb_en), 32'(rec.wb_en));
                check_value("st_en", 32'(st_en), 32'(rec.st_en));
                if (rec.wb_en) begin
                    check_value("wb_addr", 32'(wb_addr), 32'(rec.wb_addr));
                    check_value("wb_data", 32'(wb_data), 32'(rec.wb_data));
                end
                if (rec.st_en) begin
                    check_value("st_addr", 32'(st_addr), 32'(rec.st_addr));
                    check_value("st_data", 32'(st_data), 32'(rec.st_data));
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] r;
        clk         = 1'b0;
        rst_n       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cycle       = '0;
        rng_state   = 32'd94;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        // clean falling edge on rst_n
        #1 rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_value("retire_valid", 32'(retire_valid), 32'd0);
        check_value("wb_en", 32'(wb_en), 32'd0);
        check_value("st_en", 32'(st_en), 32'd0);
        // first add reads reset registers, so it retires zero
        r = next_random();
        issue_instr({cpu_pkg::OP_ADD, r[28:16]});
        for (int i = 1; i < NUM_INSTR; i++) begin
            r = next_random();
            issue_instr(r[31:16]);
        end
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        // idle tail, any stray retire trips the monitor
        repeat (4) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: compile.f
design/cpu_pkg.sv
design/reg_file.sv
design/control_unit.sv
design/decoding_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_core.sv
verif/cpu_core_assertions.sv
verif/cpu_core_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = cpu_core_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = TEST FAILED
PASS_MSG = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
